// ==== dv/pokey_io_models.sv ====
// kbd_model and pot_model, behavioral keyboard matrix and paddle rc network
`timescale 1ns/100ps

module kbd_model (
    input  logic [pokey_io_pkg::KEY_W-1:0] key_scan,    // code the dut is showing
    input  logic                           key_pressed,
    input  logic [pokey_io_pkg::KEY_W-1:0] key_code,    // which key is down
    input  logic                           shift_held,
    output logic                           kr1_l,
    output logic                           kr2_l
);

    // matrix return goes low only while the scan sits on the pressed key
    assign kr1_l = !(key_pressed && (key_scan == key_code));
    assign kr2_l = !shift_held;             // shift has its own sense line

endmodule

module pot_model (
    input  logic                                                   o2,
    input  logic                                                   rst,
    input  logic                                                   line_tick,  // from the dut
    input  logic                                                   pot_dump,
    input  logic [pokey_io_pkg::NUM_POTS*pokey_io_pkg::DATA_W-1:0] pot_target,
    output logic [pokey_io_pkg::NUM_POTS-1:0]                      pot_line,
    output int                                                     lines_seen
);

    localparam int NP = pokey_io_pkg::NUM_POTS;
    localparam int DW = pokey_io_pkg::DATA_W;

    // lines since the dump transistors let go
    always_ff @(posedge o2) begin
        if (rst || pot_dump) begin
            lines_seen <= 0;                // caps held empty
        end else if (line_tick) begin
            lines_seen <= lines_seen + 1;
        end
    end

    // each cap crosses the threshold at its own target line
    // a target past the scan length never crosses
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            pot_line[i] = !pot_dump && (lines_seen >= int'(pot_target[i*DW +: DW]));
        end
    end

endmodule

// ==== dv/pokey_io_tb.sv ====
// pokey_io_tb testbench with clock, reset, bus tasks, key and paddle stimulus, assertions, watchdog
`timescale 1ns/100ps

module pokey_io_tb;

    localparam int LINE_DIV   = 4;
    localparam int POT_LINES  = 40;
    localparam int NP         = pokey_io_pkg::NUM_POTS;
    localparam int DW         = pokey_io_pkg::DATA_W;
    localparam int PASS_CYC   = 64 * LINE_DIV;               // o2 cycles per key pass
    localparam int SCAN_CYC   = (POT_LINES + 1) * LINE_DIV;  // o2 cycles per pot scan
    localparam int KEY_PASSES = 14;                          // worst case over all key tests
    localparam int POT_SCANS  = 2;
    localparam longint WATCHDOG_NS = 4 * (KEY_PASSES * PASS_CYC + POT_SCANS * SCAN_CYC) * 100;

    logic            o2 = 1'b0;
    logic            rst;
    logic [3:0]      addr;
    logic            rd;
    logic            wr;
    logic [DW-1:0]   wdata;
    logic [DW-1:0]   rdata;
    logic [5:0]      key_scan;
    logic            kr1_l;
    logic            kr2_l;
    logic [NP-1:0]   pot_line;
    logic            pot_dump;
    logic            irq;

    logic            key_pressed;     // model controls
    logic [5:0]      key_code;
    logic            shift_held;
    logic [NP*DW-1:0] pot_target;
    int              lines_seen;

    logic [DW-1:0]   rd_exp;          // expected value of the pending read
    logic            key_armed;       // irq may rise
    int              errors = 0;
    int              n_reads = 0;
    int              seed = 41501;
    int              o2_since_rst = 0;  // o2 edges since reset let go
    logic [5:0]      key_c;
    logic [5:0]      key_b;
    wire             scan_last;

    always #50 o2 = ~o2;              // 100 ns period

    pokey_io #(.LINE_DIV(LINE_DIV), .POT_LINES(POT_LINES)) dut_i (
        .o2(o2), .rst(rst), .addr(addr), .rd(rd), .wr(wr), .wdata(wdata), .rdata(rdata),
        .key_scan(key_scan), .kr1_l(kr1_l), .kr2_l(kr2_l),
        .pot_line(pot_line), .pot_dump(pot_dump), .irq(irq)
    );

    kbd_model kbd_i (
        .key_scan(key_scan), .key_pressed(key_pressed), .key_code(key_code),
        .shift_held(shift_held), .kr1_l(kr1_l), .kr2_l(kr2_l)
    );

    pot_model pot_i (
        .o2(o2), .rst(rst), .line_tick(dut_i.line_tick), .pot_dump(pot_dump),
        .pot_target(pot_target), .pot_line(pot_line), .lines_seen(lines_seen)
    );

    // tick that must close the running scan
    assign scan_last = dut_i.line_tick && !pot_dump && (lines_seen == POT_LINES);

    // free running cycle count, restarts while reset is held
    always @(posedge o2) begin
        o2_since_rst <= rst ? 0 : o2_since_rst + 1;
    end

    read_check: assert property (@(posedge o2) disable iff (rst) rd |=> (rdata == rd_exp))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: rdata addr %0d expected %h actual %h",
                     $time, addr, rd_exp, rdata);
        end
    reset_irq: assert property (@(posedge o2) $fell(rst) |-> !irq)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: irq expected 0 actual %b", $time, irq);
        end
    reset_dump: assert property (@(posedge o2) $fell(rst) |-> pot_dump)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: pot_dump expected 1 actual %b", $time, pot_dump);
        end
    // one code step per line, first step LINE_DIV cycles after reset
    scan_timing: assert property (@(posedge o2) disable iff (rst)
        key_scan == 6'(o2_since_rst / LINE_DIV))
        else begin
            errors++;
            $display("CHECK FAILED at %0t: key_scan expected %0d actual %0d",
                     $time, 6'($sampled(o2_since_rst) / LINE_DIV), $sampled(key_scan));
        end
    irq_source: assert property (@(posedge o2) disable iff (rst) $rose(irq) |-> key_armed)
        else begin
            errors++;
            $display("irq rose at %0t although no key was held for two passes", $time);
        end
    irq_ack: assert property (@(posedge o2) disable iff (rst)
        (wr && addr == pokey_io_pkg::A_IRQ) |=> !irq)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: irq expected 0 actual %b", $time, irq);
        end
    dump_start: assert property (@(posedge o2) disable iff (rst)
        (wr && addr == pokey_io_pkg::A_POTGO) |=> !pot_dump)
        else begin
            errors++;
            $display("CHECK FAILED at %0t: pot_dump expected 0 actual %b", $time, pot_dump);
        end
    dump_end: assert property (@(posedge o2) disable iff (rst)
        !pot_dump |=> (pot_dump == $past(scan_last)))  // rises exactly on the last line
        else begin
            errors++;
            $display("CHECK FAILED at %0t: pot_dump expected %b actual %b",
                     $time, !$sampled(pot_dump), $sampled(pot_dump));
        end

    task automatic reg_read(input logic [3:0] a, input logic [DW-1:0] exp);
        @(posedge o2);
        addr   <= a;
        rd     <= 1'b1;
        rd_exp <= exp;
        n_reads++;
        @(posedge o2);
        rd <= 1'b0;
        @(posedge o2);                      // rdata checked here
    endtask

    task automatic reg_write(input logic [3:0] a);
        @(posedge o2);
        addr  <= a;
        wr    <= 1'b1;
        wdata <= DW'($random(seed));        // ignored by the dut
        @(posedge o2);
        wr <= 1'b0;
    endtask

    task automatic wait_scan(input logic [5:0] code);
        do @(posedge o2); while (key_scan != code);
    endtask

    task automatic wait_wrap();
        wait_scan(6'd63);
        wait_scan(6'd0);                    // shift_down updated by now
    endtask

    task automatic wait_irq(input int limit);
        int n;
        n = 0;
        while (!irq && n < limit) begin
            @(posedge o2);
            n++;
        end
        if (!irq) begin
            errors++;
            $display("irq did not rise within %0d cycles of the key press", limit);
        end
    endtask

    task automatic run_pot_scan(input int stuck);
        logic [DW-1:0] exp_val [NP];
        int n;
        for (int i = 0; i < NP; i++) begin
            exp_val[i] = (i == stuck) ? DW'(POT_LINES) : DW'($unsigned($random(seed)) % POT_LINES);
        end
        @(posedge o2);
        for (int i = 0; i < NP; i++) begin
            pot_target[i*DW +: DW] <= (i == stuck) ? 8'hff : exp_val[i];  // ff never crosses
        end
        reg_write(pokey_io_pkg::A_POTGO);
        n = 0;
        do begin
            @(posedge o2);
            n++;
        end while (!pot_dump && n < SCAN_CYC + 4 * LINE_DIV);
        if (!pot_dump) begin
            errors++;
            $display("pot scan still running after %0d cycles", n);
        end
        reg_read(pokey_io_pkg::A_ALLPOT, 8'h00);
        for (int i = 0; i < NP; i++) begin
            reg_read(4'(pokey_io_pkg::A_POT0 + i), exp_val[i]);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, run did not finish", $time);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        addr = '0;
        rd = 1'b0;
        wr = 1'b0;
        wdata = '0;
        key_pressed = 1'b0;
        key_code = '0;
        shift_held = 1'b0;
        pot_target = '1;
        rd_exp = '0;
        key_armed = 1'b0;
        repeat (5) @(posedge o2);
        rst <= 1'b0;

        // reset state
        for (int i = 0; i < NP; i++) begin
            reg_read(4'(pokey_io_pkg::A_POT0 + i), 8'h00);
        end
        reg_read(pokey_io_pkg::A_ALLPOT, 8'h00);
        reg_read(pokey_io_pkg::A_KBCODE, 8'h00);
        reg_read(pokey_io_pkg::A_SKSTAT, 8'hff);

        // key accepted after two passes then acked and released
        key_c = 6'($random(seed));
        @(posedge o2);
        key_code    <= key_c;
        key_armed   <= 1'b1;
        key_pressed <= 1'b1;
        wait_irq(3 * PASS_CYC + 8);
        reg_read(pokey_io_pkg::A_KBCODE, {2'b00, key_c});
        reg_read(pokey_io_pkg::A_SKSTAT, 8'hfb);     // keydown bit low
        reg_write(pokey_io_pkg::A_IRQ);
        key_armed <= 1'b0;
        reg_read(pokey_io_pkg::A_IRQ, 8'h00);
        @(posedge o2);
        key_pressed <= 1'b0;
        wait_wrap();
        wait_wrap();
        reg_read(pokey_io_pkg::A_SKSTAT, 8'hff);

        // one-pass key is bounce
        key_b = 6'($random(seed));
        if (key_b == key_c) begin
            key_b = key_c + 6'd1;
        end
        wait_scan(key_b - 6'd1);
        key_code    <= key_b;
        key_pressed <= 1'b1;
        wait_scan(key_b + 6'd1);              // seen once and gone before the next pass
        key_pressed <= 1'b0;
        wait_wrap();
        wait_wrap();
        reg_read(pokey_io_pkg::A_IRQ, 8'h00);
        reg_read(pokey_io_pkg::A_KBCODE, {2'b00, key_c});

        // paddles all crossing first and then one stuck
        run_pot_scan(-1);
        run_pot_scan($unsigned($random(seed)) % NP);

        // shift sense
        @(posedge o2);
        shift_held <= 1'b1;
        wait_wrap();
        wait_wrap();
        reg_read(pokey_io_pkg::A_SKSTAT, 8'hf7);
        @(posedge o2);
        shift_held <= 1'b0;
        wait_wrap();
        wait_wrap();
        reg_read(pokey_io_pkg::A_SKSTAT, 8'hff);

        repeat (2) @(posedge o2);             // last read check settles
        $display("summary: %0d register reads, %0d errors", n_reads, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hw/pokey_io_pkg.sv
hw/line_timer.sv
hw/key_scanner.sv
hw/pot_scanner.sv
hw/io_regs.sv
hw/pokey_io.sv
dv/pokey_io_models.sv
dv/pokey_io_tb.sv

// ==== hw/io_regs.sv ====
// io_regs module with registered read mux, potgo and irq-ack write decode, key interrupt flag
`timescale 1ns/100ps

module io_regs (
    input  logic                                                   o2,
    input  logic                                                   rst,
    input  logic [pokey_io_pkg::ADDR_W-1:0]                        addr,
    input  logic                                                   rd,
    input  logic                                                   wr,
    input  logic [pokey_io_pkg::DATA_W-1:0]                        wdata,   // value is don't-care
    output logic [pokey_io_pkg::DATA_W-1:0]                        rdata,
    input  logic [pokey_io_pkg::KEY_W-1:0]                         kbcode,
    input  logic                                                   key_down,
    input  logic                                                   shift_down,
    input  logic                                                   key_event,
    input  logic [pokey_io_pkg::NUM_POTS*pokey_io_pkg::DATA_W-1:0] pot_vals,
    input  logic [pokey_io_pkg::NUM_POTS-1:0]                      allpot,
    output logic                                                   potgo,   // write strobe
    output logic                                                   irq
);

    localparam int AW    = pokey_io_pkg::ADDR_W;
    localparam int DW    = pokey_io_pkg::DATA_W;
    localparam int NP    = pokey_io_pkg::NUM_POTS;
    localparam int SEL_W = $clog2(NP);

    logic [AW-1:0] pot_off;   // address relative to pot0
    logic [DW-1:0] rd_mux;
    logic [DW-1:0] skstat;
    logic          irq_ack;

    // both writes act on the address alone
    assign potgo   = wr && (addr == pokey_io_pkg::A_POTGO);
    assign irq_ack = wr && (addr == pokey_io_pkg::A_IRQ);
    assign pot_off = addr - pokey_io_pkg::A_POT0;

    always_comb begin
        skstat                           = '1;           // unused bits idle high
        skstat[pokey_io_pkg::SK_KEYDOWN] = ~key_down;
        skstat[pokey_io_pkg::SK_SHIFT]   = ~shift_down;
    end

    always_comb begin
        rd_mux = '0;                                     // holes read zero
        if (pot_off < AW'(NP)) begin
            rd_mux = pot_vals[pot_off[SEL_W-1:0]*DW +: DW];
        end else begin
            case (addr)
                pokey_io_pkg::A_ALLPOT: rd_mux = DW'(allpot);
                pokey_io_pkg::A_KBCODE: rd_mux = DW'(kbcode);
                pokey_io_pkg::A_IRQ:    rd_mux = DW'(irq);  // flag in bit 0
                pokey_io_pkg::A_SKSTAT: rd_mux = skstat;
                default:                rd_mux = '0;
            endcase
        end
    end

    // read data held until the next rd
    always_ff @(posedge o2) begin
        if (rst) begin
            rdata <= '0;
        end else if (rd) begin
            rdata <= rd_mux;
        end
    end

    // key interrupt, a new key beats a same-cycle ack
    always_ff @(posedge o2) begin
        if (rst) begin
            irq <= 1'b0;
        end else if (key_event) begin
            irq <= 1'b1;
        end else if (irq_ack) begin
            irq <= 1'b0;
        end
    end

endmodule

// ==== hw/key_scanner.sv ====
// key_scanner module with scan counter, compare latch, two-pass debounce, key code and shift sense
`timescale 1ns/100ps

module key_scanner (
    input  logic                             o2,
    input  logic                             rst,
    input  logic                             line_tick,   // one step of the scan
    input  logic                             kr1_l,       // matrix return, low = key at code
    input  logic                             kr2_l,       // shift sense, low = held
    output logic [pokey_io_pkg::KEY_W-1:0]   key_scan,    // code shown to the matrix
    output logic [pokey_io_pkg::KEY_W-1:0]   kbcode,      // last accepted key
    output logic                             key_down,
    output logic                             shift_down,
    output logic                             key_event    // one-cycle pulse on accept
);

    localparam int KW = pokey_io_pkg::KEY_W;

    logic [KW-1:0] scan_ctr;    // walks 0..63 once per pass
    logic [KW-1:0] cmp_latch;   // code of the first sighting
    logic          key_depr;    // a candidate key is being tracked
    logic          cmp_match;   // scan is back at the candidate
    logic          last_code;   // final code of the pass
    logic          shift_acc;   // kr2_l seen low somewhere this pass

    assign key_scan  = scan_ctr;
    assign cmp_match = (scan_ctr == cmp_latch);
    assign last_code = (scan_ctr == {KW{1'b1}});

    // scan counter and debounce
    // kr1_l is compared against the code on key_scan in the same tick
    always_ff @(posedge o2) begin
        if (rst) begin
            scan_ctr  <= '0;
            cmp_latch <= '0;
            key_depr  <= 1'b0;
            key_down  <= 1'b0;
            kbcode    <= '0;
            key_event <= 1'b0;
        end else begin
            key_event <= 1'b0;              // pulse lasts one cycle
            if (line_tick) begin
                scan_ctr <= scan_ctr + 1'b1;    // wraps 63 -> 0 by width

                if (!kr1_l) begin
                    if (!key_depr) begin
                        // first sighting, remember where
                        cmp_latch <= scan_ctr;
                        key_depr  <= 1'b1;
                    end else if (cmp_match && !key_down) begin
                        // same code one pass later so the key is real
                        kbcode    <= scan_ctr;
                        key_down  <= 1'b1;
                        key_event <= 1'b1;
                    end
                    // other keys while tracking one are ignored
                end else if (key_depr && cmp_match) begin
                    // return high at our code
                    // release, or bounce if never confirmed
                    key_depr <= 1'b0;
                    key_down <= 1'b0;
                end
            end
        end
    end

    // shift sense
    // gathered over a whole pass, published as the code wraps
    always_ff @(posedge o2) begin
        if (rst) begin
            shift_acc  <= 1'b0;
            shift_down <= 1'b0;
        end else if (line_tick) begin
            if (last_code) begin
                shift_down <= shift_acc | ~kr2_l;   // include the last code too
                shift_acc  <= 1'b0;                 // fresh pass
            end else begin
                shift_acc  <= shift_acc | ~kr2_l;
            end
        end
    end

endmodule

// ==== hw/line_timer.sv ====
// line timer module, divides o2 down to a one-cycle line strobe
`timescale 1ns/100ps

module line_timer #(
    parameter int LINE_DIV = 114           // o2 cycles per tv line
) (
    input  logic o2,
    input  logic rst,
    output logic line_tick                 // one o2 cycle per line
);

    // counter just wide enough for LINE_DIV-1
    localparam int CNT_W = (LINE_DIV > 1) ? $clog2(LINE_DIV) : 1;
    localparam logic [CNT_W-1:0] CNT_TOP = CNT_W'(LINE_DIV - 1);

    logic [CNT_W-1:0] div_cnt;             // counts down, zero marks the strobe

    always_ff @(posedge o2) begin
        if (rst) begin
            div_cnt <= CNT_TOP;            // first strobe LINE_DIV cycles out
        end else if (div_cnt == '0) begin
            div_cnt <= CNT_TOP;            // reload for next line
        end else begin
            div_cnt <= div_cnt - 1'b1;
        end
    end

    // decoded straight from the counter
    // paces both the key scan and the paddle count
    assign line_tick = (div_cnt == '0);

endmodule

// ==== hw/pokey_io.sv ====
// pokey_io top level wiring the line timer, key scanner, pot scanner and register block
`timescale 1ns/100ps

module pokey_io #(
    parameter int LINE_DIV  = 114,   // o2 cycles per line
    parameter int POT_LINES = 228    // paddle scan length in lines
) (
    input  logic                                 o2,
    input  logic                                 rst,
    input  logic [pokey_io_pkg::ADDR_W-1:0]      addr,
    input  logic                                 rd,
    input  logic                                 wr,
    input  logic [pokey_io_pkg::DATA_W-1:0]      wdata,
    output logic [pokey_io_pkg::DATA_W-1:0]      rdata,
    output logic [pokey_io_pkg::KEY_W-1:0]       key_scan,
    input  logic                                 kr1_l,
    input  logic                                 kr2_l,
    input  logic [pokey_io_pkg::NUM_POTS-1:0]    pot_line,
    output logic                                 pot_dump,
    output logic                                 irq
);

    logic                                                   line_tick;
    logic [pokey_io_pkg::KEY_W-1:0]                         kbcode;
    logic                                                   key_down;
    logic                                                   shift_down;
    logic                                                   key_event;
    logic [pokey_io_pkg::NUM_POTS*pokey_io_pkg::DATA_W-1:0] pot_vals;
    logic [pokey_io_pkg::NUM_POTS-1:0]                      allpot;
    logic                                                   potgo;

    line_timer #(
        .LINE_DIV (LINE_DIV)
    ) line_timer_i (
        .o2        (o2),
        .rst       (rst),
        .line_tick (line_tick)
    );

    key_scanner key_scanner_i (
        .o2         (o2),
        .rst        (rst),
        .line_tick  (line_tick),
        .kr1_l      (kr1_l),
        .kr2_l      (kr2_l),
        .key_scan   (key_scan),
        .kbcode     (kbcode),
        .key_down   (key_down),
        .shift_down (shift_down),
        .key_event  (key_event)
    );

    pot_scanner #(
        .POT_LINES (POT_LINES)
    ) pot_scanner_i (
        .o2        (o2),
        .rst       (rst),
        .line_tick (line_tick),
        .potgo     (potgo),
        .pot_line  (pot_line),
        .pot_vals  (pot_vals),
        .allpot    (allpot),
        .pot_dump  (pot_dump)
    );

    io_regs io_regs_i (
        .o2         (o2),
        .rst        (rst),
        .addr       (addr),
        .rd         (rd),
        .wr         (wr),
        .wdata      (wdata),
        .rdata      (rdata),
        .kbcode     (kbcode),
        .key_down   (key_down),
        .shift_down (shift_down),
        .key_event  (key_event),
        .pot_vals   (pot_vals),
        .allpot     (allpot),
        .potgo      (potgo),
        .irq        (irq)
    );

endmodule

// ==== hw/pokey_io_pkg.sv ====
// bus widths, register addresses and skstat bit positions for the pokey keyboard/paddle block
package pokey_io_pkg;

    // bus and field widths
    localparam int ADDR_W   = 4;
    localparam int DATA_W   = 8;
    localparam int KEY_W    = 6;   // 64 key matrix
    localparam int NUM_POTS = 8;

    // read side
    localparam logic [ADDR_W-1:0] A_POT0   = 4'd0;   // pot0..pot7 at 0..7
    localparam logic [ADDR_W-1:0] A_ALLPOT = 4'd8;   // busy mask
    localparam logic [ADDR_W-1:0] A_KBCODE = 4'd9;   // last accepted key

    // write side
    localparam logic [ADDR_W-1:0] A_POTGO  = 4'd11;  // start paddle scan

    // shared address
    // read gives irq status, any write clears the key interrupt
    localparam logic [ADDR_W-1:0] A_IRQ    = 4'd14;

    localparam logic [ADDR_W-1:0] A_SKSTAT = 4'd15;  // keyboard status

    // skstat bits, both active low like the original part
    localparam int SK_KEYDOWN = 2;
    localparam int SK_SHIFT   = 3;

endpackage

// ==== hw/pot_scanner.sv ====
// pot_scanner module with line counter, eight pot latches, allpot busy mask and dump control
`timescale 1ns/100ps

module pot_scanner #(
    parameter int POT_LINES = 228              // last count of a scan
) (
    input  logic                                                o2,
    input  logic                                                rst,
    input  logic                                                line_tick,
    input  logic                                                potgo,     // start pulse
    input  logic [pokey_io_pkg::NUM_POTS-1:0]                   pot_line,  // high once charged
    output logic [pokey_io_pkg::NUM_POTS*pokey_io_pkg::DATA_W-1:0] pot_vals,
    output logic [pokey_io_pkg::NUM_POTS-1:0]                   allpot,    // 1 = still measuring
    output logic                                                pot_dump   // high holds caps empty
);

    localparam int NP = pokey_io_pkg::NUM_POTS;
    localparam int DW = pokey_io_pkg::DATA_W;
    localparam logic [DW-1:0] LAST_LINE = DW'(POT_LINES);

    logic [DW-1:0] line_cnt;   // lines since potgo
    logic          scan_step;  // a tick inside a running scan
    logic          at_last;    // this tick closes the scan

    // dump released means a measurement is running
    assign scan_step = line_tick && !pot_dump;
    assign at_last   = (line_cnt == LAST_LINE);

    always_ff @(posedge o2) begin
        if (rst) begin
            line_cnt <= '0;
            allpot   <= '0;
            pot_vals <= '0;
            pot_dump <= 1'b1;                  // caps discharged out of reset
        end else if (potgo) begin
            // restart even mid-scan
            line_cnt <= '0;
            allpot   <= '1;
            pot_vals <= '0;
            pot_dump <= 1'b0;                  // let the caps charge
        end else if (scan_step) begin
            for (int i = 0; i < NP; i++) begin
                // first rise of a busy pot captures the count
                // at the end every busy pot takes POT_LINES
                if (allpot[i] && (pot_line[i] || at_last)) begin
                    pot_vals[i*DW +: DW] <= line_cnt;
                    allpot[i]            <= 1'b0;
                end
            end

            if (at_last) begin
                pot_dump <= 1'b1;              // scan over, dump transistors on
            end else begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the pokey_io testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
    -f files.f --top-module pokey_io_tb -o pokey_io_sim || exit 1

out=$(./obj_dir/pokey_io_sim)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" || exit 1
